/* src/bridge_settings.svh */
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// bus widths
`define BRIDGE_ADDR_WIDTH 32
`define BRIDGE_DATA_WIDTH 32
`define BRIDGE_ID_WIDTH 6
`define BRIDGE_STRB_WIDTH 4

// in-flight request kinds kept for in-order return
`define BRIDGE_ORDER_DEPTH 4

`endif

/* src/bridge_pkg.sv */
`include "bridge_settings.svh"

package bridge_pkg;

	// ==================================================
	// vector types
	typedef logic [`BRIDGE_ADDR_WIDTH-1:0] addr_t;
	typedef logic [`BRIDGE_DATA_WIDTH-1:0] data_t;
	typedef logic [`BRIDGE_STRB_WIDTH-1:0] strb_t;
	typedef logic [2:0] size_t;
	typedef logic [2:0] slave_id_t;
	// match_id in the upper bits, slave number below
	typedef logic [`BRIDGE_ID_WIDTH-1:0] axi_id_t;

	// ==================================================
	// enums
	typedef enum logic {KIND_READ = 1'b0, KIND_WRITE = 1'b1} kind_t;

	// addr_data means neither AW nor W has been taken yet
	typedef enum logic [2:0] {W_IDLE, W_ADDR_DATA, W_ADDR, W_DATA, W_RESP} w_state_t;

	typedef enum logic [1:0] {R_IDLE, R_ADDR, R_DATA} r_state_t;

endpackage

/* src/sram_req_if.sv */
interface sram_req_if;

	// one-cycle strobes, high with mem_addr_ok
	logic wr_go;
	logic rd_go;
	bridge_pkg::kind_t kind;
	// remapped address and formed id
	bridge_pkg::addr_t addr;
	bridge_pkg::size_t size;
	bridge_pkg::data_t wdata;
	bridge_pkg::strb_t wmask;
	bridge_pkg::axi_id_t id;

	modport decode (
		output wr_go, rd_go, kind, addr, size, wdata, wmask, id
	);

	modport wmaster (
		input wr_go, addr, size, wdata, wmask, id
	);

	modport rmaster (
		input rd_go, addr, size, id
	);

	modport merge (
		input wr_go, rd_go, kind
	);

endinterface

/* src/sram_req_decode.sv */
`include "bridge_settings.svh"

module sram_req_decode (
	input  logic                aclk,
	input  logic                reset,
	input  logic                mem_req,
	input  logic                mem_wen,
	input  logic                mem_ren,
	input  bridge_pkg::addr_t   mem_address,
	input  bridge_pkg::data_t   mem_wdata,
	input  bridge_pkg::strb_t   mem_wmask,
	input  bridge_pkg::size_t   mem_size,
	input  logic [2:0]          match_id,
	input  logic                w_idle,
	input  logic                r_idle,
	input  logic                order_full,
	input  logic                writing,
	input  bridge_pkg::addr_t   last_write_address,
	output logic                mem_addr_ok,
	sram_req_if.decode          req
);

	logic [3:0] region;
	bridge_pkg::slave_id_t slave_id;
	bridge_pkg::addr_t remap_addr;
	logic want_wr;
	logic want_rd;
	logic raw_hold;
	logic wr_ok;
	logic rd_ok;

	// ==================================================
	// slave decode on the top nibble
	assign region = mem_address[`BRIDGE_ADDR_WIDTH-1 -: 4];

	always_comb begin
		case (region)
			4'h0, 4'h1: slave_id = 3'b001;
			4'h2:       slave_id = 3'b011;
			4'h4:       slave_id = 3'b111;
			default:    slave_id = 3'b000;
		endcase
	end

	assign remap_addr = {4'h0, mem_address[`BRIDGE_ADDR_WIDTH-5:0]};

	// ==================================================
	// acceptance
	assign want_wr = mem_req && mem_wen;
	assign want_rd = mem_req && mem_ren && !mem_wen;
	// read must not pass a write to the same word still on the bus
	assign raw_hold = writing && (remap_addr == last_write_address);

	assign wr_ok = want_wr && w_idle && !order_full;
	assign rd_ok = want_rd && r_idle && !order_full && !raw_hold;
	assign mem_addr_ok = wr_ok || rd_ok;

	assign req.wr_go = wr_ok;
	assign req.rd_go = rd_ok;
	assign req.kind = mem_wen ? bridge_pkg::KIND_WRITE : bridge_pkg::KIND_READ;
	assign req.addr = remap_addr;
	assign req.size = mem_size;
	assign req.wdata = mem_wdata;
	assign req.wmask = mem_wmask;
	assign req.id = {match_id, slave_id};

	// the hold compares against the address the write master took
	assert property (@(posedge aclk) disable iff (reset)
		req.wr_go |=> writing && (last_write_address == $past(req.addr)));

	// an accepted read starts the read master
	assert property (@(posedge aclk) disable iff (reset)
		req.rd_go |=> !r_idle);

endmodule

/* src/axi_w_channel_master.sv */
module axi_w_channel_master (
	input  logic                  aclk,
	input  logic                  reset,
	sram_req_if.wmaster           req,
	output bridge_pkg::addr_t     awaddr,
	output logic [3:0]            awlen,
	output bridge_pkg::size_t     awsize,
	output logic [1:0]            awburst,
	output bridge_pkg::axi_id_t   awid,
	output logic                  awvalid,
	input  logic                  awready,
	output bridge_pkg::data_t     wdata,
	output bridge_pkg::strb_t     wstrb,
	output logic                  wlast,
	output bridge_pkg::axi_id_t   wid,
	output logic                  wvalid,
	input  logic                  wready,
	input  logic [1:0]            bresp,
	input  bridge_pkg::axi_id_t   bid,
	input  logic                  bvalid,
	output logic                  bready,
	output logic                  w_idle,
	output logic                  w_done,
	output logic                  writing,
	output bridge_pkg::addr_t     last_write_address
);

	bridge_pkg::w_state_t state;
	bridge_pkg::w_state_t state_next;

	// ==================================================
	// write FSM, AW and W taken in either order
	always_comb begin
		state_next = state;
		case (state)
			bridge_pkg::W_IDLE: begin
				if (req.wr_go) begin
					state_next = bridge_pkg::W_ADDR_DATA;
				end
			end
			bridge_pkg::W_ADDR_DATA: begin
				if (awready && wready) begin
					state_next = bridge_pkg::W_RESP;
				end else if (awready) begin
					state_next = bridge_pkg::W_DATA;
				end else if (wready) begin
					state_next = bridge_pkg::W_ADDR;
				end
			end
			bridge_pkg::W_ADDR: begin
				if (awready) begin
					state_next = bridge_pkg::W_RESP;
				end
			end
			bridge_pkg::W_DATA: begin
				if (wready) begin
					state_next = bridge_pkg::W_RESP;
				end
			end
			bridge_pkg::W_RESP: begin
				if (bvalid) begin
					state_next = bridge_pkg::W_IDLE;
				end
			end
			default: state_next = bridge_pkg::W_IDLE;
		endcase
	end

	always_ff @(posedge aclk) begin
		if (reset) begin
			state <= bridge_pkg::W_IDLE;
			w_done <= 1'b0;
		end else begin
			state <= state_next;
			w_done <= (state == bridge_pkg::W_RESP) && bvalid;
		end
	end

	// request payload, held for the whole transaction
	always_ff @(posedge aclk) begin
		if (req.wr_go) begin
			awaddr <= req.addr;
			awsize <= req.size;
			awid <= req.id;
			wdata <= req.wdata;
			wstrb <= req.wmask;
		end
	end

	// ==================================================
	// channel outputs
	assign awvalid = (state == bridge_pkg::W_ADDR_DATA) || (state == bridge_pkg::W_ADDR);
	assign wvalid = (state == bridge_pkg::W_ADDR_DATA) || (state == bridge_pkg::W_DATA);
	assign bready = (state == bridge_pkg::W_RESP);
	// single beat, INCR
	assign awlen = 4'd0;
	assign awburst = 2'b01;
	assign wlast = 1'b1;
	assign wid = awid;

	assign w_idle = (state == bridge_pkg::W_IDLE);
	assign writing = !w_idle;
	assign last_write_address = awaddr;

	assert property (@(posedge aclk) disable iff (reset)
		awvalid && !awready |=> awvalid && $stable(awaddr));

	// response belongs to the write that was sent
	assert property (@(posedge aclk) disable iff (reset)
		bvalid && bready |-> (bid == awid) && !$isunknown(bresp));

endmodule

/* src/axi_r_channel_master.sv */
module axi_r_channel_master (
	input  logic                  aclk,
	input  logic                  reset,
	sram_req_if.rmaster           req,
	output bridge_pkg::addr_t     araddr,
	output logic [3:0]            arlen,
	output bridge_pkg::size_t     arsize,
	output logic [1:0]            arburst,
	output bridge_pkg::axi_id_t   arid,
	output logic                  arvalid,
	input  logic                  arready,
	input  bridge_pkg::data_t     rdata,
	input  logic [1:0]            rresp,
	input  logic                  rlast,
	input  bridge_pkg::axi_id_t   rid,
	input  logic                  rvalid,
	output logic                  rready,
	output logic                  r_idle,
	output logic                  r_done,
	output bridge_pkg::data_t     r_data
);

	bridge_pkg::r_state_t state;

	// ==================================================
	// read FSM
	always_ff @(posedge aclk) begin
		if (reset) begin
			state <= bridge_pkg::R_IDLE;
			r_done <= 1'b0;
		end else begin
			r_done <= 1'b0;
			case (state)
				bridge_pkg::R_IDLE: begin
					if (req.rd_go) begin
						state <= bridge_pkg::R_ADDR;
					end
				end
				bridge_pkg::R_ADDR: begin
					if (arready) begin
						state <= bridge_pkg::R_DATA;
					end
				end
				bridge_pkg::R_DATA: begin
					if (rvalid) begin
						state <= bridge_pkg::R_IDLE;
						r_done <= 1'b1;
					end
				end
				default: state <= bridge_pkg::R_IDLE;
			endcase
		end
	end

	// address payload and returned word
	always_ff @(posedge aclk) begin
		if (req.rd_go) begin
			araddr <= req.addr;
			arsize <= req.size;
			arid <= req.id;
		end
		if (rvalid && rready) begin
			r_data <= rdata;
		end
	end

	assign arvalid = (state == bridge_pkg::R_ADDR);
	assign rready = (state == bridge_pkg::R_DATA);
	assign arlen = 4'd0;
	assign arburst = 2'b01;
	assign r_idle = (state == bridge_pkg::R_IDLE);

	assert property (@(posedge aclk) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr));

	// one beat back, tagged with the id that went out on AR
	assert property (@(posedge aclk) disable iff (reset)
		rvalid && rready |-> rlast && (rid == arid) && !$isunknown(rresp));

endmodule

/* src/srambus_resp_merge.sv */
`include "bridge_settings.svh"

module srambus_resp_merge (
	input  logic                aclk,
	input  logic                reset,
	sram_req_if.merge           req,
	input  logic                w_done,
	input  logic                r_done,
	input  bridge_pkg::data_t   r_data,
	output logic                order_full,
	output logic                mem_data_ok,
	output bridge_pkg::data_t   mem_rdata
);

	localparam int DEPTH = `BRIDGE_ORDER_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	bridge_pkg::kind_t order_q [DEPTH];
	bridge_pkg::kind_t head;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W:0] count;
	logic done_w;
	logic done_r;
	logic push;
	logic pop;
	logic head_done;

	// ==================================================
	// head of the order queue
	assign push = req.wr_go || req.rd_go;
	assign head = order_q[rd_ptr];

	always_comb begin
		if (head == bridge_pkg::KIND_WRITE) begin
			head_done = w_done || done_w;
		end else begin
			head_done = r_done || done_r;
		end
	end

	assign pop = (count != '0) && head_done;
	assign mem_data_ok = pop;
	assign mem_rdata = r_data;
	// also closed while a completion waits behind an older request,
	// so a sticky flag or r_data is never overwritten
	assign order_full = (count == (PTR_W+1)'(DEPTH)) || done_w || done_r;

	always_ff @(posedge aclk) begin
		if (push) begin
			order_q[wr_ptr] <= req.kind;
		end
	end

	always_ff @(posedge aclk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
			done_w <= 1'b0;
			done_r <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
			end
			case ({push, pop})
				2'b10: count <= count + (PTR_W+1)'(1);
				2'b01: count <= count - (PTR_W+1)'(1);
				default: count <= count;
			endcase
			// completions that finish out of order wait here
			done_w <= (done_w || w_done) && !(pop && head == bridge_pkg::KIND_WRITE);
			done_r <= (done_r || r_done) && !(pop && head == bridge_pkg::KIND_READ);
		end
	end

	assert property (@(posedge aclk) disable iff (reset)
		push |-> count != (PTR_W+1)'(DEPTH));

endmodule

/* src/srambus2axi.sv */
module srambus2axi (
	input  logic                  aclk,
	input  logic                  reset,
	// write address channel
	output bridge_pkg::addr_t     awaddr,
	output logic [3:0]            awlen,
	output bridge_pkg::size_t     awsize,
	output logic [1:0]            awburst,
	output bridge_pkg::axi_id_t   awid,
	output logic                  awvalid,
	input  logic                  awready,
	// write data channel
	output bridge_pkg::data_t     wdata,
	output bridge_pkg::strb_t     wstrb,
	output logic                  wlast,
	output bridge_pkg::axi_id_t   wid,
	output logic                  wvalid,
	input  logic                  wready,
	// write response channel
	input  logic [1:0]            bresp,
	input  bridge_pkg::axi_id_t   bid,
	input  logic                  bvalid,
	output logic                  bready,
	// read address channel
	output bridge_pkg::addr_t     araddr,
	output logic [3:0]            arlen,
	output bridge_pkg::size_t     arsize,
	output logic [1:0]            arburst,
	output bridge_pkg::axi_id_t   arid,
	output logic                  arvalid,
	input  logic                  arready,
	// read data channel
	input  bridge_pkg::data_t     rdata,
	input  logic [1:0]            rresp,
	input  logic                  rlast,
	input  bridge_pkg::axi_id_t   rid,
	input  logic                  rvalid,
	output logic                  rready,
	// SRAM-style bus
	input  logic                  mem_req,
	input  logic                  mem_wen,
	input  logic                  mem_ren,
	input  bridge_pkg::addr_t     mem_address,
	input  bridge_pkg::data_t     mem_wdata,
	input  bridge_pkg::strb_t     mem_wmask,
	input  bridge_pkg::size_t     mem_size,
	input  logic [2:0]            match_id,
	output logic                  mem_addr_ok,
	output logic                  mem_data_ok,
	output bridge_pkg::data_t     mem_rdata
);

	logic w_idle;
	logic r_idle;
	logic order_full;
	logic writing;
	logic w_done;
	logic r_done;
	bridge_pkg::addr_t last_write_address;
	bridge_pkg::data_t r_data;

	sram_req_if req_bus ();

	sram_req_decode u_decode (
		.aclk(aclk), .reset(reset),
		.mem_req(mem_req), .mem_wen(mem_wen), .mem_ren(mem_ren),
		.mem_address(mem_address), .mem_wdata(mem_wdata), .mem_wmask(mem_wmask),
		.mem_size(mem_size), .match_id(match_id),
		.w_idle(w_idle), .r_idle(r_idle), .order_full(order_full),
		.writing(writing), .last_write_address(last_write_address),
		.mem_addr_ok(mem_addr_ok), .req(req_bus.decode)
	);

	axi_w_channel_master u_wmaster (
		.aclk(aclk), .reset(reset), .req(req_bus.wmaster),
		.awaddr(awaddr), .awlen(awlen), .awsize(awsize), .awburst(awburst),
		.awid(awid), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wid(wid),
		.wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bid(bid), .bvalid(bvalid), .bready(bready),
		.w_idle(w_idle), .w_done(w_done), .writing(writing),
		.last_write_address(last_write_address)
	);

	axi_r_channel_master u_rmaster (
		.aclk(aclk), .reset(reset), .req(req_bus.rmaster),
		.araddr(araddr), .arlen(arlen), .arsize(arsize), .arburst(arburst),
		.arid(arid), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rlast(rlast), .rid(rid),
		.rvalid(rvalid), .rready(rready),
		.r_idle(r_idle), .r_done(r_done), .r_data(r_data)
	);

	srambus_resp_merge u_merge (
		.aclk(aclk), .reset(reset), .req(req_bus.merge),
		.w_done(w_done), .r_done(r_done), .r_data(r_data),
		.order_full(order_full), .mem_data_ok(mem_data_ok), .mem_rdata(mem_rdata)
	);

endmodule

/* verif/tb_srambus2axi.sv */
module tb_srambus2axi;

	localparam int N_ENTRIES = 15;
	localparam int TIMEOUT = 40 * N_ENTRIES;
	localparam int SLOW_B = 8;
	// single beat, word size, INCR
	localparam logic [8:0] SINGLE_BEAT = {4'd0, 3'b010, 2'b01};

	typedef struct packed {
		logic is_wr;
		logic drain;
		logic slow_b;
		logic [2:0] mid;
		bridge_pkg::addr_t addr;
		bridge_pkg::data_t wdata;
		bridge_pkg::strb_t wmask;
		bridge_pkg::data_t exp;
	} entry_t;

	logic aclk = 1'b0;
	logic reset;
	bridge_pkg::addr_t awaddr;
	logic [3:0] awlen;
	bridge_pkg::size_t awsize;
	logic [1:0] awburst;
	bridge_pkg::axi_id_t awid;
	logic awvalid;
	logic awready;
	bridge_pkg::data_t wdata;
	bridge_pkg::strb_t wstrb;
	logic wlast;
	bridge_pkg::axi_id_t wid;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	bridge_pkg::axi_id_t bid;
	logic bvalid;
	logic bready;
	bridge_pkg::addr_t araddr;
	logic [3:0] arlen;
	bridge_pkg::size_t arsize;
	logic [1:0] arburst;
	bridge_pkg::axi_id_t arid;
	logic arvalid;
	logic arready;
	bridge_pkg::data_t rdata;
	logic [1:0] rresp;
	logic rlast;
	bridge_pkg::axi_id_t rid;
	logic rvalid;
	logic rready;
	logic mem_req;
	logic mem_wen;
	logic mem_ren;
	bridge_pkg::addr_t mem_address;
	bridge_pkg::data_t mem_wdata;
	bridge_pkg::strb_t mem_wmask;
	bridge_pkg::size_t mem_size;
	logic [2:0] match_id;
	logic mem_addr_ok;
	logic mem_data_ok;
	bridge_pkg::data_t mem_rdata;

	entry_t tbl [N_ENTRIES];
	int ord [N_ENTRIES];
	int write_entry [N_ENTRIES];
	int issued = 0;
	int resp_idx = 0;
	int data_ok_count = 0;
	int errors = 0;
	int tests_done = 0;
	int tests_bad = 0;
	int idle_faults = 0;
	int cycles = 0;
	logic quiet = 1'b0;

	// slave model state
	bridge_pkg::data_t mem [bridge_pkg::addr_t];
	bridge_pkg::addr_t aw_addr;
	bridge_pkg::axi_id_t aw_id;
	bridge_pkg::addr_t ar_addr;
	bridge_pkg::axi_id_t ar_id;
	// len, size and burst as seen on the bus
	logic [8:0] aw_attr;
	logic [8:0] ar_attr;
	bridge_pkg::axi_id_t w_id;
	logic w_last;
	bridge_pkg::data_t w_word;
	bridge_pkg::strb_t w_mask;
	logic have_aw, have_w, b_pend, r_pend;
	logic aw_seen, w_seen, ar_seen;
	logic aw_fire, w_fire, b_fire, ar_fire, r_fire;
	int aw_cnt, w_cnt, ar_cnt, b_cnt, r_cnt;
	int b_count = 0;
	int r_count = 0;
	int wr_land = 0;

	srambus2axi u_dut (.*);

	always #10 aclk = ~aclk;

	// ==================================================
	// reference rules
	function automatic bridge_pkg::slave_id_t slave_of(logic [3:0] nibble);
		case (nibble)
			4'h0, 4'h1: return 3'b001;
			4'h2: return 3'b011;
			4'h4: return 3'b111;
			default: return 3'b000;
		endcase
	endfunction

	// unwritten words read back a pattern of their own address
	function automatic bridge_pkg::data_t mem_read(bridge_pkg::addr_t a);
		bridge_pkg::addr_t key;
		key = {a[31:2], 2'b00};
		if (mem.exists(key)) begin
			return mem[key];
		end
		return key ^ 32'h5a5a_a5a5;
	endfunction

	task automatic mem_write(input bridge_pkg::addr_t a, input bridge_pkg::data_t d,
			input bridge_pkg::strb_t m);
		bridge_pkg::data_t word;
		word = mem_read(a);
		for (int lane = 0; lane < 4; lane++) begin
			if (m[lane]) begin
				word[8*lane +: 8] = d[8*lane +: 8];
			end
		end
		mem[{a[31:2], 2'b00}] = word;
	endtask

	// ready rises 0 to 3 cycles after valid is seen
	task automatic step_ready(input logic seen, input logic fire, inout logic ready,
			inout int cnt);
		if (fire) begin
			ready = 1'b0;
			cnt = int'($urandom % 4);
		end else if (seen && !ready) begin
			if (cnt == 0) begin
				ready = 1'b1;
			end else begin
				cnt = cnt - 1;
			end
		end
	endtask

	task automatic build_table();
		int nw;
		int nr;
		// is_wr drain slow_b mid addr wdata wmask exp
		tbl[0]  = '{1'b1, 1'b1, 1'b0, 3'd2, 32'h0000_0010, 32'h1122_3344, 4'hf, 32'h0};
		tbl[1]  = '{1'b0, 1'b0, 1'b0, 3'd2, 32'h0000_0010, 32'h0, 4'h0, 32'h1122_3344};
		tbl[2]  = '{1'b1, 1'b1, 1'b0, 3'd5, 32'h1000_0020, 32'ha0b0_c0d0, 4'hf, 32'h0};
		tbl[3]  = '{1'b1, 1'b0, 1'b0, 3'd5, 32'h1000_0020, 32'hffee_ddcc, 4'h5, 32'h0};
		tbl[4]  = '{1'b0, 1'b0, 1'b0, 3'd1, 32'h1000_0020, 32'h0, 4'h0, 32'ha0ee_c0cc};
		tbl[5]  = '{1'b1, 1'b1, 1'b0, 3'd7, 32'h2000_0104, 32'hdead_beef, 4'hf, 32'h0};
		tbl[6]  = '{1'b1, 1'b0, 1'b0, 3'd7, 32'h2000_0104, 32'h0000_1200, 4'h2, 32'h0};
		tbl[7]  = '{1'b0, 1'b0, 1'b0, 3'd6, 32'h2000_0104, 32'h0, 4'h0, 32'hdead_12ef};
		tbl[8]  = '{1'b1, 1'b1, 1'b0, 3'd0, 32'h4000_0208, 32'h0bad_f00d, 4'hf, 32'h0};
		tbl[9]  = '{1'b0, 1'b0, 1'b0, 3'd4, 32'h4000_0208, 32'h0, 4'h0, 32'h0bad_f00d};
		// unmapped region, upper half written over the fill pattern
		tbl[10] = '{1'b1, 1'b1, 1'b0, 3'd3, 32'h7000_0300, 32'h1357_9bdf, 4'hc, 32'h0};
		tbl[11] = '{1'b0, 1'b0, 1'b0, 3'd3, 32'h7000_0300, 32'h0, 4'h0, 32'h1357_a6a5};
		// slow B, the read behind it finishes first on AXI
		tbl[12] = '{1'b1, 1'b1, 1'b1, 3'd2, 32'h0000_0400, 32'h2468_ace0, 4'hf, 32'h0};
		tbl[13] = '{1'b0, 1'b0, 1'b0, 3'd2, 32'h0000_0010, 32'h0, 4'h0, 32'h1122_3344};
		tbl[14] = '{1'b0, 1'b0, 1'b0, 3'd2, 32'h0000_0400, 32'h0, 4'h0, 32'h2468_ace0};
		nw = 0;
		nr = 0;
		for (int i = 0; i < N_ENTRIES; i++) begin
			if (tbl[i].is_wr) begin
				ord[i] = nw;
				write_entry[nw] = i;
				nw++;
			end else begin
				ord[i] = nr;
				nr++;
			end
		end
	endtask

	// ==================================================
	// compare tasks
	task automatic check_addr(input string what, input bridge_pkg::addr_t got,
			input bridge_pkg::addr_t exp);
		if (got !== exp) begin
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_id(input string what, input bridge_pkg::axi_id_t got,
			input bridge_pkg::axi_id_t exp);
		if (got !== exp) begin
			$display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_data(input string what, input bridge_pkg::data_t got,
			input bridge_pkg::data_t exp);
		if (got !== exp) begin
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_attr(input string what, input logic [8:0] got,
			input logic [8:0] exp);
		if (got !== exp) begin
			$display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_response(input int idx);
		bridge_pkg::addr_t exp_addr;
		bridge_pkg::axi_id_t exp_id;
		int errs_before;
		exp_addr = {4'h0, tbl[idx].addr[27:0]};
		exp_id = {tbl[idx].mid, slave_of(tbl[idx].addr[31:28])};
		errs_before = errors;
		if (tbl[idx].is_wr) begin
			check_addr($sformatf("entry %0d awaddr", idx), aw_addr, exp_addr);
			check_id($sformatf("entry %0d awid", idx), aw_id, exp_id);
			check_id($sformatf("entry %0d wid", idx), w_id, exp_id);
			check_attr($sformatf("entry %0d awlen awsize awburst", idx), aw_attr,
				SINGLE_BEAT);
			if (w_last !== 1'b1) begin
				$display("FAIL %0t: entry %0d wlast is %b, expected 1", $time, idx, w_last);
				errors++;
			end
			if (b_count <= ord[idx]) begin
				$display("FAIL %0t: entry %0d done before its B handshake", $time, idx);
				errors++;
			end
		end else begin
			check_addr($sformatf("entry %0d araddr", idx), ar_addr, exp_addr);
			check_id($sformatf("entry %0d arid", idx), ar_id, exp_id);
			check_attr($sformatf("entry %0d arlen arsize arburst", idx), ar_attr,
				SINGLE_BEAT);
			check_data($sformatf("entry %0d mem_rdata", idx), mem_rdata, tbl[idx].exp);
			if (r_count <= ord[idx]) begin
				$display("FAIL %0t: entry %0d done before its R handshake", $time, idx);
				errors++;
			end
		end
		tests_done++;
		if (errors != errs_before) begin
			tests_bad++;
			$display("entry %0d %s %h: errors", idx, tbl[idx].is_wr ? "write" : "read",
				tbl[idx].addr);
		end else begin
			$display("entry %0d %s %h: ok", idx, tbl[idx].is_wr ? "write" : "read",
				tbl[idx].addr);
		end
	endtask

	// ==================================================
	// AXI slave model, samples before the edge and drives after it
	initial begin
		void'($urandom(32'h1006));
		awready = 1'b0;
		wready = 1'b0;
		arready = 1'b0;
		bvalid = 1'b0;
		bresp = 2'b00;
		bid = '0;
		rvalid = 1'b0;
		rresp = 2'b00;
		rlast = 1'b1;
		rid = '0;
		rdata = '0;
		have_aw = 1'b0;
		have_w = 1'b0;
		b_pend = 1'b0;
		r_pend = 1'b0;
		aw_cnt = 0;
		w_cnt = 0;
		ar_cnt = 0;
		b_cnt = 0;
		r_cnt = 0;
		forever begin
			@(negedge aclk);
			aw_seen = awvalid;
			w_seen = wvalid;
			ar_seen = arvalid;
			aw_fire = awvalid && awready;
			w_fire = wvalid && wready;
			b_fire = bvalid && bready;
			ar_fire = arvalid && arready;
			r_fire = rvalid && rready;
			if (aw_fire) begin
				aw_addr = awaddr;
				aw_id = awid;
				aw_attr = {awlen, awsize, awburst};
				have_aw = 1'b1;
			end
			if (w_fire) begin
				w_word = wdata;
				w_mask = wstrb;
				w_id = wid;
				w_last = wlast;
				have_w = 1'b1;
			end
			if (ar_fire) begin
				ar_addr = araddr;
				ar_id = arid;
				ar_attr = {arlen, arsize, arburst};
			end
			@(posedge aclk);
			#1;
			step_ready(aw_seen, aw_fire, awready, aw_cnt);
			step_ready(w_seen, w_fire, wready, w_cnt);
			step_ready(ar_seen, ar_fire, arready, ar_cnt);
			// write lands once address and data are both in
			if (have_aw && have_w) begin
				mem_write(aw_addr, w_word, w_mask);
				have_aw = 1'b0;
				have_w = 1'b0;
				bid = aw_id;
				b_cnt = tbl[write_entry[wr_land]].slow_b ? SLOW_B : int'($urandom % 4);
				wr_land++;
				b_pend = 1'b1;
			end
			if (b_fire) begin
				bvalid = 1'b0;
				b_count++;
			end
			if (b_pend) begin
				if (b_cnt == 0) begin
					bvalid = 1'b1;
					b_pend = 1'b0;
				end else begin
					b_cnt--;
				end
			end
			if (r_fire) begin
				rvalid = 1'b0;
				r_count++;
			end
			if (ar_fire) begin
				rdata = mem_read(ar_addr);
				rid = ar_id;
				r_cnt = int'($urandom % 4);
				r_pend = 1'b1;
			end
			if (r_pend) begin
				if (r_cnt == 0) begin
					rvalid = 1'b1;
					r_pend = 1'b0;
				end else begin
					r_cnt--;
				end
			end
		end
	end

	// ==================================================
	// response monitor
	always @(negedge aclk) begin
		if (!reset) begin
			if (quiet && (awvalid || wvalid || arvalid || bready || rready || mem_data_ok)) begin
				$display("bus activity at time %0t while no request was made", $time);
				idle_faults++;
				errors++;
			end
			if (mem_data_ok) begin
				data_ok_count++;
				if (resp_idx >= issued) begin
					$display("mem_data_ok at time %0t with no request outstanding", $time);
					errors++;
				end else begin
					check_response(resp_idx);
					resp_idx++;
				end
			end
		end
	end

	always @(posedge aclk) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("run stopped after %0d cycles with %0d of %0d responses received",
				cycles, resp_idx, N_ENTRIES);
			$display("Test failed");
			$finish;
		end
	end

	// ==================================================
	// stimulus
	initial begin
		reset = 1'b1;
		mem_req = 1'b0;
		mem_wen = 1'b0;
		mem_ren = 1'b0;
		mem_address = '0;
		mem_wdata = '0;
		mem_wmask = '0;
		mem_size = 3'b010;
		match_id = 3'b000;
		build_table();
		repeat (5) @(posedge aclk);
		#1;
		reset = 1'b0;
		// no requests yet, bus must stay quiet
		quiet = 1'b1;
		repeat (5) @(posedge aclk);
		#1;
		quiet = 1'b0;
		$display("idle check after reset: %0d faults", idle_faults);
		for (int i = 0; i < N_ENTRIES; i++) begin
			if (tbl[i].drain && resp_idx != issued) begin
				while (resp_idx != issued) @(posedge aclk);
				#1;
			end
			mem_req = 1'b1;
			mem_wen = tbl[i].is_wr;
			mem_ren = !tbl[i].is_wr;
			mem_address = tbl[i].addr;
			mem_wdata = tbl[i].wdata;
			mem_wmask = tbl[i].wmask;
			match_id = tbl[i].mid;
			@(negedge aclk);
			while (!mem_addr_ok) @(negedge aclk);
			@(posedge aclk);
			#1;
			issued++;
			mem_req = 1'b0;
			mem_wen = 1'b0;
			mem_ren = 1'b0;
		end
		while (resp_idx != issued) @(posedge aclk);
		// a few more cycles to catch a stray mem_data_ok
		repeat (5) @(posedge aclk);
		$display("%0d tests, %0d with errors, %0d mem_data_ok pulses for %0d accepted requests",
			tests_done, tests_bad, data_ok_count, issued);
		if (data_ok_count != issued) begin
			$display("number of responses does not match the accepted requests");
		end
		if (errors == 0 && data_ok_count == issued && tests_done == N_ENTRIES) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* compile.f */
+incdir+src
src/bridge_pkg.sv
src/sram_req_if.sv
src/sram_req_decode.sv
src/axi_w_channel_master.sv
src/axi_r_channel_master.sv
src/srambus_resp_merge.sv
src/srambus2axi.sv
verif/tb_srambus2axi.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the SRAM-bus to AXI bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -f compile.f \
	--top-module tb_srambus2axi -Mdir "$BUILD" -o tb_srambus2axi
if [ $? -ne 0 ]; then
	echo "Verilator build did not complete"
	exit 1
fi

"./$BUILD/tb_srambus2axi" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# verdict comes from the log
if grep -q "Test failed" "$LOG"; then
	exit 1
fi
exit 0
